/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f files.f --top-module tb_rvv_dispatch -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir

/* dispatch_ctrl.sv */
// ------------------------------
// In-order issue decision
// RAW check between the slots
// Queue and ROB handshakes
// ------------------------------

`timescale 1ns/1ps

module dispatch_ctrl (
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                          uop_valid_uop2dp,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                          vd_valid,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0] vd_index,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0] vs1_index,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                          vs1_valid,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0] vs2_index,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                          vs2_valid,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                          vs3_valid,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                          rob_hazard,
    input  logic                                                         strct_hazard,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                          uop_ready_rob2dp,
    input  logic                                                         rs_can_load,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0]                          uop_ready_dp2uop,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0]                          uop_valid_dp2rob,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0]                          issue
);

    logic raw_uop_uop;

    // Slot 1 reads the register that slot 0 is about to write
    assign raw_uop_uop = uop_valid_uop2dp[0] & vd_valid[0] &
                         ((vs1_valid[1] & (vs1_index[1] == vd_index[0])) |
                          (vs2_valid[1] & (vs2_index[1] == vd_index[0])) |
                          (vs3_valid[1] & (vd_index[1] == vd_index[0])));

    // ROB valid leaves out every ROB ready term
    assign uop_valid_dp2rob[0] = uop_valid_uop2dp[0] & ~rob_hazard[0] & rs_can_load;
    assign uop_valid_dp2rob[1] = uop_valid_dp2rob[0] & uop_valid_uop2dp[1] &
                                 ~rob_hazard[1] & ~raw_uop_uop & ~strct_hazard;

    // Slot 1 never goes ahead of slot 0
    assign issue[0] = uop_valid_dp2rob[0] & uop_ready_rob2dp[0];
    assign issue[1] = issue[0] & uop_valid_dp2rob[1] & uop_ready_rob2dp[1];

    assign uop_ready_dp2uop = issue;

endmodule

/* dispatch_pkg.sv */
// ------------------------------
// Dispatch stage package
// Widths and counts shared by
// every dispatch module
// ------------------------------

package dispatch_pkg;

    // Micro-op slots handled per cycle
    localparam int NUM_DP_UOP = 2;

    // VRF read ports
    localparam int NUM_VRF_RD = 4;

    // Sources per micro-op in the order vs2, vs1, vd
    localparam int NUM_SRC = 3;

    // Register index and vector register width
    localparam int REG_IDX_W = 5;
    localparam int VLEN = 32;

    // Reorder buffer size and index width
    localparam int ROB_DEPTH = 8;
    localparam int ROB_IDX_W = 3;

    // Operation code width
    localparam int FUNCT6_W = 6;

    // Read-port number width
    localparam int PORT_IDX_W = 2;

endpackage

/* dispatch_rob_bypass.sv */
// ------------------------------
// RAW check of one micro-op
// against the ROB entries and
// ROB or VRF operand selection
// ------------------------------

`timescale 1ns/1ps

module dispatch_rob_bypass (
    input  logic [dispatch_pkg::REG_IDX_W-1:0]                          vs1_index,
    input  logic                                                        vs1_valid,
    input  logic [dispatch_pkg::REG_IDX_W-1:0]                          vs2_index,
    input  logic                                                        vs2_valid,
    input  logic [dispatch_pkg::REG_IDX_W-1:0]                          vd_index,
    input  logic                                                        vs3_valid,
    input  logic [dispatch_pkg::VLEN-1:0]                               vrf_vs1_data,
    input  logic [dispatch_pkg::VLEN-1:0]                               vrf_vs2_data,
    input  logic [dispatch_pkg::VLEN-1:0]                               vrf_vd_data,
    input  logic [dispatch_pkg::ROB_DEPTH-1:0]                          rob_valid,
    input  logic [dispatch_pkg::ROB_DEPTH-1:0][dispatch_pkg::REG_IDX_W-1:0] rob_w_index,
    input  logic [dispatch_pkg::ROB_DEPTH-1:0]                          rob_w_done,
    input  logic [dispatch_pkg::ROB_DEPTH-1:0][dispatch_pkg::VLEN-1:0]  rob_w_data,
    output logic                                                        rob_hazard,
    output logic [dispatch_pkg::VLEN-1:0]                               vs1_data,
    output logic [dispatch_pkg::VLEN-1:0]                               vs2_data,
    output logic [dispatch_pkg::VLEN-1:0]                               vd_data
);

    logic [dispatch_pkg::NUM_SRC-1:0][dispatch_pkg::REG_IDX_W-1:0] src_index;
    logic [dispatch_pkg::NUM_SRC-1:0]                              src_valid;
    logic [dispatch_pkg::NUM_SRC-1:0][dispatch_pkg::VLEN-1:0]      src_vrf;
    logic [dispatch_pkg::NUM_SRC-1:0][dispatch_pkg::VLEN-1:0]      src_data;
    logic [dispatch_pkg::NUM_SRC-1:0]                              hit;
    logic [dispatch_pkg::NUM_SRC-1:0]                              hit_done;
    logic [dispatch_pkg::NUM_SRC-1:0][dispatch_pkg::VLEN-1:0]      hit_data;

    // Source 0 is vs2, source 2 is vd read as a source
    assign src_index = {vd_index, vs1_index, vs2_index};
    assign src_valid = {vs3_valid, vs1_valid, vs2_valid};
    assign src_vrf   = {vrf_vd_data, vrf_vs1_data, vrf_vs2_data};

    // Scan from oldest to youngest so the youngest writer wins
    always_comb begin
        hit      = '0;
        hit_done = '0;
        hit_data = '0;
        for (int s = 0; s < dispatch_pkg::NUM_SRC; s++) begin
            for (int e = 0; e < dispatch_pkg::ROB_DEPTH; e++) begin
                if (rob_valid[e] && (rob_w_index[e] == src_index[s])) begin
                    hit[s]      = 1'b1;
                    hit_done[s] = rob_w_done[e];
                    hit_data[s] = rob_w_data[e];
                end
            end
        end
    end

    // Pending result on any used source stalls the micro-op
    assign rob_hazard = |(src_valid & hit & ~hit_done);

    always_comb begin
        for (int s = 0; s < dispatch_pkg::NUM_SRC; s++) begin
            src_data[s] = (hit[s] && hit_done[s]) ? hit_data[s] : src_vrf[s];
        end
    end

    assign {vd_data, vs1_data, vs2_data} = src_data;

endmodule

/* dispatch_rs_reg.sv */
// ------------------------------
// Two-slot output register
// toward the ALU reservation
// station
// ------------------------------

`timescale 1ns/1ps

module dispatch_rs_reg (
    input  logic                                                       clk,
    input  logic                                                       rst_n,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                        issue,
    input  logic [dispatch_pkg::ROB_IDX_W-1:0]                         uop_index_rob2dp,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::FUNCT6_W-1:0] funct6,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] vs1_data,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] vs2_data,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] vd_data,
    input  logic [dispatch_pkg::VLEN-1:0]                              v0_mask_vrf2dp,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                        rs_ready_alu2dp,
    output logic                                                       rs_can_load,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0]                        rs_valid_dp2alu,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::ROB_IDX_W-1:0] rs_rob_idx,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::FUNCT6_W-1:0] rs_funct6,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] rs_vs1_data,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] rs_vs2_data,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] rs_vd_data,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] rs_v0_data
);

    // Each slot is empty or handed over in this cycle
    assign rs_can_load = &(~rs_valid_dp2alu | rs_ready_alu2dp);

    // A slot keeps its micro-op until the RS takes it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rs_valid_dp2alu <= '0;
        end else begin
            rs_valid_dp2alu <= issue | (rs_valid_dp2alu & ~rs_ready_alu2dp);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < dispatch_pkg::NUM_DP_UOP; i++) begin
            if (issue[i]) begin
                // Slot i takes the i-th free ROB entry
                rs_rob_idx[i]  <= uop_index_rob2dp + dispatch_pkg::ROB_IDX_W'(i);
                rs_funct6[i]   <= funct6[i];
                rs_vs1_data[i] <= vs1_data[i];
                rs_vs2_data[i] <= vs2_data[i];
                rs_vd_data[i]  <= vd_data[i];
                rs_v0_data[i]  <= v0_mask_vrf2dp;
            end
        end
    end

endmodule

/* dispatch_stimulus.txt */
# Three lines per vector. A: name uop_valid funct6_0 funct6_1 flags0 flags1 vs2_0 vs1_0 vd_0
#   vs2_1 vs1_1 vd_1 rob_ready rob_base rs_ready v0 (flags = vd_valid vs3_valid vs1_valid vs2_valid)
# B: rob_valid rob_done rob_w_index[0..7]
# C: exp_ready exp_rob_valid rd_index[0..3] exp_rs_valid, per slot: rob_idx funct6 vs1 vs2 vd
pair_clean 3 01 02 b b 01 02 03 04 05 06 3 2 3 0000ffff
00 00 00 00 00 00 00 00 00 00
3 3 01 02 04 05 3 2 01 d0d00001 d0d00000 00000000 3 02 d0d00003 d0d00002 00000000
rob_pending 3 11 12 b b 01 02 03 04 05 06 3 2 3 0000ffff
02 00 00 02 00 00 00 00 00 00
0 0 01 02 04 05 0 0 00 00000000 00000000 00000000 0 00 00000000 00000000 00000000
rob_bypass 3 03 04 b b 01 02 03 04 05 06 3 4 3 0000ffff
52 12 00 02 00 00 02 00 09 00
3 3 01 02 04 05 3 4 03 a0a00004 d0d00000 00000000 5 04 d0d00003 d0d00002 00000000
uop_raw 3 05 06 b b 01 02 03 04 03 06 3 6 3 0000ffff
00 00 00 00 00 00 00 00 00 00
1 1 01 02 04 03 1 6 05 d0d00001 d0d00000 00000000 0 00 00000000 00000000 00000000
struct_haz 3 07 08 f b 01 02 03 04 05 06 3 0 3 0000ffff
00 00 00 00 00 00 00 00 00 00
1 1 01 02 03 04 1 0 07 d0d00001 d0d00000 d0d00002 0 00 00000000 00000000 00000000
rs_hold_a 3 09 0a b b 01 02 03 04 05 06 3 1 0 5555aaaa
00 00 00 00 00 00 00 00 00 00
0 0 01 02 04 05 1 0 07 d0d00001 d0d00000 d0d00002 0 00 00000000 00000000 00000000
rs_hold_b 3 09 0a b b 01 02 03 04 05 06 3 1 0 5555aaaa
00 00 00 00 00 00 00 00 00 00
0 0 01 02 04 05 1 0 07 d0d00001 d0d00000 d0d00002 0 00 00000000 00000000 00000000
rs_release 3 09 0a b b 01 02 03 04 05 06 3 1 1 5555aaaa
00 00 00 00 00 00 00 00 00 00
3 3 01 02 04 05 3 1 09 d0d00001 d0d00000 00000000 2 0a d0d00003 d0d00002 00000000
rob_busy0 3 0b 0c b b 01 02 03 04 05 06 2 3 3 5555aaaa
00 00 00 00 00 00 00 00 00 00
0 3 01 02 04 05 0 0 00 00000000 00000000 00000000 0 00 00000000 00000000 00000000
rob_busy1 3 0b 0c b b 01 02 03 04 05 06 1 3 3 5555aaaa
00 00 00 00 00 00 00 00 00 00
1 3 01 02 04 05 1 3 0b d0d00001 d0d00000 00000000 0 00 00000000 00000000 00000000
idle 0 00 00 0 0 01 02 03 04 05 06 3 4 3 5555aaaa
00 00 00 00 00 00 00 00 00 00
0 0 00 00 00 00 0 0 00 00000000 00000000 00000000 0 00 00000000 00000000 00000000

/* dispatch_vrf_ports.sv */
// ------------------------------
// VRF read-port allocation
// Structure hazard flag and
// read data routing per source
// ------------------------------

`timescale 1ns/1ps

module dispatch_vrf_ports (
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0] vs1_index,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                          vs1_valid,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0] vs2_index,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                          vs2_valid,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0] vd_index,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                          vs3_valid,
    input  logic [dispatch_pkg::NUM_VRF_RD-1:0][dispatch_pkg::VLEN-1:0]  rd_data_vrf2dp,
    output logic [dispatch_pkg::NUM_VRF_RD-1:0][dispatch_pkg::REG_IDX_W-1:0] rd_index_dp2vrf,
    output logic                                                         strct_hazard,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0]  vrf_vs1_data,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0]  vrf_vs2_data,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0]  vrf_vd_data
);

    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::NUM_SRC-1:0]
        [dispatch_pkg::REG_IDX_W-1:0] src_index;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::NUM_SRC-1:0] src_valid;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::NUM_SRC-1:0]
        [dispatch_pkg::PORT_IDX_W-1:0] src_port;
    // One extra bit so the count can exceed the port number range
    logic [dispatch_pkg::PORT_IDX_W:0] rd_cnt;

    genvar i;
    generate
        for (i = 0; i < dispatch_pkg::NUM_DP_UOP; i++) begin : gen_slot
            assign src_index[i] = {vd_index[i], vs1_index[i], vs2_index[i]};
            assign src_valid[i] = {vs3_valid[i], vs1_valid[i], vs2_valid[i]};

            // Return data from the port each source was given
            assign vrf_vs2_data[i] = rd_data_vrf2dp[src_port[i][0]];
            assign vrf_vs1_data[i] = rd_data_vrf2dp[src_port[i][1]];
            assign vrf_vd_data[i]  = rd_data_vrf2dp[src_port[i][2]];
        end
    endgenerate

    // Ports go out in order over slot 0 then slot 1
    always_comb begin
        rd_index_dp2vrf = '0;
        src_port        = '0;
        rd_cnt          = '0;
        for (int u = 0; u < dispatch_pkg::NUM_DP_UOP; u++) begin
            for (int s = 0; s < dispatch_pkg::NUM_SRC; s++) begin
                if (src_valid[u][s]) begin
                    if (rd_cnt < dispatch_pkg::NUM_VRF_RD) begin
                        rd_index_dp2vrf[rd_cnt[dispatch_pkg::PORT_IDX_W-1:0]] = src_index[u][s];
                        src_port[u][s] = rd_cnt[dispatch_pkg::PORT_IDX_W-1:0];
                    end
                    rd_cnt = rd_cnt + 1'b1;
                end
            end
        end
    end

    // Slot 0 alone never runs out of ports
    assign strct_hazard = (rd_cnt > dispatch_pkg::NUM_VRF_RD);

endmodule

/* files.f */
dispatch_pkg.sv
dispatch_rob_bypass.sv
dispatch_vrf_ports.sv
dispatch_ctrl.sv
dispatch_rs_reg.sv
rvv_dispatch.sv
tb_rvv_dispatch.sv

/* rvv_dispatch.sv */
// ------------------------------
// Vector dispatch stage top
// VRF ports, ROB bypass, issue
// control and ALU RS register
// ------------------------------

`timescale 1ns/1ps

module rvv_dispatch (
    input  logic                                                       clk,
    input  logic                                                       rst_n,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                        uop_valid_uop2dp,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0] vs1_index,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                        vs1_valid,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0] vs2_index,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                        vs2_valid,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0] vd_index,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                        vd_valid,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                        vs3_valid,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::FUNCT6_W-1:0] funct6,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0]                        uop_ready_dp2uop,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0]                        uop_valid_dp2rob,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0] rob_w_index_dp2rob,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::FUNCT6_W-1:0] rob_funct6_dp2rob,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                        uop_ready_rob2dp,
    input  logic [dispatch_pkg::ROB_IDX_W-1:0]                         uop_index_rob2dp,
    input  logic [dispatch_pkg::ROB_DEPTH-1:0]                         rob_valid,
    input  logic [dispatch_pkg::ROB_DEPTH-1:0][dispatch_pkg::REG_IDX_W-1:0] rob_w_index,
    input  logic [dispatch_pkg::ROB_DEPTH-1:0]                         rob_w_done,
    input  logic [dispatch_pkg::ROB_DEPTH-1:0][dispatch_pkg::VLEN-1:0] rob_w_data,
    output logic [dispatch_pkg::NUM_VRF_RD-1:0][dispatch_pkg::REG_IDX_W-1:0] rd_index_dp2vrf,
    input  logic [dispatch_pkg::NUM_VRF_RD-1:0][dispatch_pkg::VLEN-1:0] rd_data_vrf2dp,
    input  logic [dispatch_pkg::VLEN-1:0]                              v0_mask_vrf2dp,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0]                        rs_valid_dp2alu,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::ROB_IDX_W-1:0] rs_rob_idx,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::FUNCT6_W-1:0] rs_funct6,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] rs_vs1_data,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] rs_vs2_data,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] rs_vd_data,
    output logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] rs_v0_data,
    input  logic [dispatch_pkg::NUM_DP_UOP-1:0]                        rs_ready_alu2dp
);

    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] vrf_vs1_data;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] vrf_vs2_data;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] vrf_vd_data;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] opn_vs1_data;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] opn_vs2_data;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0] opn_vd_data;
    logic [dispatch_pkg::NUM_DP_UOP-1:0]                         rob_hazard;
    logic [dispatch_pkg::NUM_DP_UOP-1:0]                         issue;
    logic                                                        strct_hazard;
    logic                                                        rs_can_load;

    // ROB push fields
    assign rob_w_index_dp2rob = vd_index;
    assign rob_funct6_dp2rob  = funct6;

    dispatch_vrf_ports u_vrf_ports (
        .vs1_index       (vs1_index),
        .vs1_valid       (vs1_valid),
        .vs2_index       (vs2_index),
        .vs2_valid       (vs2_valid),
        .vd_index        (vd_index),
        .vs3_valid       (vs3_valid),
        .rd_data_vrf2dp  (rd_data_vrf2dp),
        .rd_index_dp2vrf (rd_index_dp2vrf),
        .strct_hazard    (strct_hazard),
        .vrf_vs1_data    (vrf_vs1_data),
        .vrf_vs2_data    (vrf_vs2_data),
        .vrf_vd_data     (vrf_vd_data)
    );

    genvar i;
    generate
        for (i = 0; i < dispatch_pkg::NUM_DP_UOP; i++) begin : gen_bypass
            dispatch_rob_bypass u_rob_bypass (
                .vs1_index    (vs1_index[i]),
                .vs1_valid    (vs1_valid[i]),
                .vs2_index    (vs2_index[i]),
                .vs2_valid    (vs2_valid[i]),
                .vd_index     (vd_index[i]),
                .vs3_valid    (vs3_valid[i]),
                .vrf_vs1_data (vrf_vs1_data[i]),
                .vrf_vs2_data (vrf_vs2_data[i]),
                .vrf_vd_data  (vrf_vd_data[i]),
                .rob_valid    (rob_valid),
                .rob_w_index  (rob_w_index),
                .rob_w_done   (rob_w_done),
                .rob_w_data   (rob_w_data),
                .rob_hazard   (rob_hazard[i]),
                .vs1_data     (opn_vs1_data[i]),
                .vs2_data     (opn_vs2_data[i]),
                .vd_data      (opn_vd_data[i])
            );
        end
    endgenerate

    dispatch_ctrl u_ctrl (
        .uop_valid_uop2dp (uop_valid_uop2dp),
        .vd_valid         (vd_valid),
        .vd_index         (vd_index),
        .vs1_index        (vs1_index),
        .vs1_valid        (vs1_valid),
        .vs2_index        (vs2_index),
        .vs2_valid        (vs2_valid),
        .vs3_valid        (vs3_valid),
        .rob_hazard       (rob_hazard),
        .strct_hazard     (strct_hazard),
        .uop_ready_rob2dp (uop_ready_rob2dp),
        .rs_can_load      (rs_can_load),
        .uop_ready_dp2uop (uop_ready_dp2uop),
        .uop_valid_dp2rob (uop_valid_dp2rob),
        .issue            (issue)
    );

    dispatch_rs_reg u_rs_reg (
        .clk              (clk),
        .rst_n            (rst_n),
        .issue            (issue),
        .uop_index_rob2dp (uop_index_rob2dp),
        .funct6           (funct6),
        .vs1_data         (opn_vs1_data),
        .vs2_data         (opn_vs2_data),
        .vd_data          (opn_vd_data),
        .v0_mask_vrf2dp   (v0_mask_vrf2dp),
        .rs_ready_alu2dp  (rs_ready_alu2dp),
        .rs_can_load      (rs_can_load),
        .rs_valid_dp2alu  (rs_valid_dp2alu),
        .rs_rob_idx       (rs_rob_idx),
        .rs_funct6        (rs_funct6),
        .rs_vs1_data      (rs_vs1_data),
        .rs_vs2_data      (rs_vs2_data),
        .rs_vd_data       (rs_vd_data),
        .rs_v0_data       (rs_v0_data)
    );

endmodule

/* tb_rvv_dispatch.sv */
// ------------------------------
// Testbench for rvv_dispatch
// Reads vectors from a file,
// drives the DUT, checks results
// ------------------------------

`timescale 1ns/1ps

module tb_rvv_dispatch;

    logic clk;
    logic rst_n;
    logic [dispatch_pkg::NUM_DP_UOP-1:0]                                     uop_valid_uop2dp;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0]        vs1_index;
    logic [dispatch_pkg::NUM_DP_UOP-1:0]                                     vs1_valid;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0]        vs2_index;
    logic [dispatch_pkg::NUM_DP_UOP-1:0]                                     vs2_valid;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0]        vd_index;
    logic [dispatch_pkg::NUM_DP_UOP-1:0]                                     vd_valid;
    logic [dispatch_pkg::NUM_DP_UOP-1:0]                                     vs3_valid;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::FUNCT6_W-1:0]         funct6;
    logic [dispatch_pkg::NUM_DP_UOP-1:0]                                     uop_ready_dp2uop;
    logic [dispatch_pkg::NUM_DP_UOP-1:0]                                     uop_valid_dp2rob;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::REG_IDX_W-1:0]        rob_w_index_dp2rob;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::FUNCT6_W-1:0]         rob_funct6_dp2rob;
    logic [dispatch_pkg::NUM_DP_UOP-1:0]                                     uop_ready_rob2dp;
    logic [dispatch_pkg::ROB_IDX_W-1:0]                                      uop_index_rob2dp;
    logic [dispatch_pkg::ROB_DEPTH-1:0]                                      rob_valid;
    logic [dispatch_pkg::ROB_DEPTH-1:0][dispatch_pkg::REG_IDX_W-1:0]         rob_w_index;
    logic [dispatch_pkg::ROB_DEPTH-1:0]                                      rob_w_done;
    logic [dispatch_pkg::ROB_DEPTH-1:0][dispatch_pkg::VLEN-1:0]              rob_w_data;
    logic [dispatch_pkg::NUM_VRF_RD-1:0][dispatch_pkg::REG_IDX_W-1:0]        rd_index_dp2vrf;
    logic [dispatch_pkg::NUM_VRF_RD-1:0][dispatch_pkg::VLEN-1:0]             rd_data_vrf2dp;
    logic [dispatch_pkg::VLEN-1:0]                                           v0_mask_vrf2dp;
    logic [dispatch_pkg::NUM_DP_UOP-1:0]                                     rs_valid_dp2alu;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::ROB_IDX_W-1:0]        rs_rob_idx;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::FUNCT6_W-1:0]         rs_funct6;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0]             rs_vs1_data;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0]             rs_vs2_data;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0]             rs_vd_data;
    logic [dispatch_pkg::NUM_DP_UOP-1:0][dispatch_pkg::VLEN-1:0]             rs_v0_data;
    logic [dispatch_pkg::NUM_DP_UOP-1:0]                                     rs_ready_alu2dp;

    int fd;

    rvv_dispatch dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // Run limit in case the vector loop stalls
    initial begin
        #100000;
        $display("simulation ran past its time limit");
        stop_run();
    end

    task automatic check_issue(input string name,
                               input logic [dispatch_pkg::NUM_DP_UOP-1:0] exp_rdy,
                               input logic [dispatch_pkg::NUM_DP_UOP-1:0] exp_robv);
        if (uop_ready_dp2uop !== exp_rdy || uop_valid_dp2rob !== exp_robv) begin
            $display("mismatch %s ready/rob_valid expected %b/%b actual %b/%b",
                     name, exp_rdy, exp_robv, uop_ready_dp2uop, uop_valid_dp2rob);
            stop_run();
        end
    endtask

    task automatic check_rob_push(input string name, input int slot,
        input logic [dispatch_pkg::REG_IDX_W-1:0] exp_widx,
        input logic [dispatch_pkg::FUNCT6_W-1:0] exp_f6);
        if (rob_w_index_dp2rob[slot] !== exp_widx ||
            rob_funct6_dp2rob[slot] !== exp_f6) begin
            $display("mismatch %s slot %0d rob push expected %h/%h actual %h/%h",
                     name, slot, exp_widx, exp_f6, rob_w_index_dp2rob[slot],
                     rob_funct6_dp2rob[slot]);
            stop_run();
        end
    endtask

    task automatic check_rd_index(input string name,
        input logic [dispatch_pkg::NUM_VRF_RD-1:0][dispatch_pkg::REG_IDX_W-1:0] exp_idx);
        if (rd_index_dp2vrf !== exp_idx) begin
            $display("mismatch %s rd_index expected %h actual %h",
                     name, exp_idx, rd_index_dp2vrf);
            stop_run();
        end
    endtask

    task automatic check_rs(input string name, input int slot, input string field,
                            input logic [dispatch_pkg::VLEN-1:0] exp_val,
                            input logic [dispatch_pkg::VLEN-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("mismatch %s slot %0d %s expected %h actual %h",
                     name, slot, field, exp_val, act_val);
            stop_run();
        end
    endtask

    // Next line that is neither blank nor a comment
    task automatic read_line(output string text, output bit ok);
        int n;
        ok = 1'b0;
        for (int k = 0; k < 1000 && !ok; k++) begin
            text = "";
            n = $fgets(text, fd);
            if (n == 0) break;
            if (text.len() > 1 && text[0] != "#") ok = 1'b1;
        end
    endtask

    initial begin
        string la, lb, lc, tname;
        bit ok;
        int n;
        logic [31:0] uv, f0, f1, fl0, fl1, a0, b0, c0, a1, b1, c1, rrdy, base, rsr, v0;
        logic [31:0] rv, rd, ri [8];
        logic [31:0] er, eb, x0, x1, x2, x3, ev, q [10];
        logic [1:0][3:0] held_fl;
        logic [1:0][31:0] held_v0;
        logic [3:0] fl;

        held_fl = '0;
        held_v0 = '0;
        void'($urandom(32'h66cf));
        rst_n = 1'b0;
        {uop_valid_uop2dp, vs1_index, vs1_valid, vs2_index, vs2_valid} = '0;
        {vd_index, vd_valid, vs3_valid, funct6, uop_ready_rob2dp} = '0;
        {uop_index_rob2dp, rob_valid, rob_w_index, rob_w_done} = '0;
        rob_w_data = '0;
        v0_mask_vrf2dp = '0;
        rs_ready_alu2dp = '0;
        for (int p = 0; p < dispatch_pkg::NUM_VRF_RD; p++) begin
            rd_data_vrf2dp[p] = 32'hd0d0_0000 + 32'(p);
        end
        fd = $fopen("dispatch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            stop_run();
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int k = 0; k < 10 && rs_valid_dp2alu != '0; k++) @(negedge clk);
        if (rs_valid_dp2alu != '0) begin
            $display("RS valid did not clear after reset");
            stop_run();
        end

        forever begin
            read_line(la, ok);
            if (!ok) break;
            read_line(lb, ok);
            if (ok) read_line(lc, ok);
            if (!ok) begin
                $display("stimulus file ends inside a vector");
                stop_run();
            end
            n = $sscanf(la, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", tname, uv,
                        f0, f1, fl0, fl1, a0, b0, c0, a1, b1, c1, rrdy, base, rsr, v0);
            n += $sscanf(lb, "%h %h %h %h %h %h %h %h %h %h", rv, rd,
                         ri[0], ri[1], ri[2], ri[3], ri[4], ri[5], ri[6], ri[7]);
            n += $sscanf(lc, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         er, eb, x0, x1, x2, x3, ev, q[0], q[1], q[2], q[3], q[4],
                         q[5], q[6], q[7], q[8], q[9]);
            if (n != 43) begin
                $display("badly formed vector after %s", tname);
                stop_run();
            end

            @(negedge clk);
            uop_valid_uop2dp = uv[1:0];
            funct6 = {f1[5:0], f0[5:0]};
            {vd_valid[0], vs3_valid[0], vs1_valid[0], vs2_valid[0]} = fl0[3:0];
            {vd_valid[1], vs3_valid[1], vs1_valid[1], vs2_valid[1]} = fl1[3:0];
            vs2_index = {a1[4:0], a0[4:0]};
            vs1_index = {b1[4:0], b0[4:0]};
            vd_index = {c1[4:0], c0[4:0]};
            uop_ready_rob2dp = rrdy[1:0];
            uop_index_rob2dp = base[2:0];
            rs_ready_alu2dp = rsr[1:0];
            v0_mask_vrf2dp = v0;
            rob_valid = rv[7:0];
            rob_w_done = rd[7:0];
            for (int e = 0; e < dispatch_pkg::ROB_DEPTH; e++) begin
                rob_w_index[e] = ri[e][4:0];
                // Entries that are not valid carry noise
                rob_w_data[e] = rob_valid[e] ? 32'ha0a0_0000 + 32'(e) : $urandom();
            end

            // Combinational outputs just before the rising edge
            #4;
            check_issue(tname, er[1:0], eb[1:0]);
            // A pushed micro-op writes its own vd and carries its own funct6
            if (eb[0]) check_rob_push(tname, 0, c0[4:0], f0[5:0]);
            if (eb[1]) check_rob_push(tname, 1, c1[4:0], f1[5:0]);
            check_rd_index(tname, {x3[4:0], x2[4:0], x1[4:0], x0[4:0]});
            for (int i = 0; i < dispatch_pkg::NUM_DP_UOP; i++) begin
                if (er[i]) begin
                    held_fl[i] = (i == 0) ? fl0[3:0] : fl1[3:0];
                    held_v0[i] = v0;
                end
            end

            @(posedge clk);
            #1;
            check_rs(tname, 0, "valid", 32'(ev[1:0]), 32'(rs_valid_dp2alu));
            for (int i = 0; i < dispatch_pkg::NUM_DP_UOP; i++) begin
                fl = held_fl[i];
                if (ev[i]) begin
                    check_rs(tname, i, "rob_idx", q[i*5], 32'(rs_rob_idx[i]));
                    check_rs(tname, i, "funct6", q[i*5+1], 32'(rs_funct6[i]));
                    check_rs(tname, i, "v0", held_v0[i], rs_v0_data[i]);
                    if (fl[1]) check_rs(tname, i, "vs1", q[i*5+2], rs_vs1_data[i]);
                    if (fl[0]) check_rs(tname, i, "vs2", q[i*5+3], rs_vs2_data[i]);
                    if (fl[2]) check_rs(tname, i, "vd", q[i*5+4], rs_vd_data[i]);
                end
            end
        end
        $fclose(fd);

        $display("NO ERRORS");
        $finish;
    end

endmodule
